// File: design/access_gate.sv
// XOSVM memory access gate
`timescale 1ns/1ps
`default_nettype none

module access_gate (
    // Used by the checker only
    input  logic                                                     clk,
    input  logic                                                     rst_n_i,

    // Translator results by channel
    input  logic [xosvm_pkg::NUM_CHANNELS-1:0][xosvm_pkg::XLEN-1:0]  addr_i,
    input  logic [xosvm_pkg::NUM_CHANNELS-1:0]                       fault_i,

    // Memory request from the core side
    input  logic                                                     mem_read_i,
    input  logic [xosvm_pkg::WE_W-1:0]                               mem_we_i,

    // Instruction side
    output logic [xosvm_pkg::XLEN-1:0]                               instr_addr_o,
    output logic                                                     instr_fault_o,

    // Data side
    output logic [xosvm_pkg::XLEN-1:0]                               mem_addr_o,
    output logic                                                     mem_fault_o,
    output logic                                                     mem_op_en_o,
    output logic [xosvm_pkg::WE_W-1:0]                               mem_we_o
);

    // Any read or byte write pending
    logic mem_req;

    assign mem_req = mem_read_i || (mem_we_i != '0);

    // Fetch side goes straight out
    assign instr_addr_o  = addr_i[xosvm_pkg::CH_INSTR];
    assign instr_fault_o = fault_i[xosvm_pkg::CH_INSTR];

    assign mem_addr_o    = addr_i[xosvm_pkg::CH_DATA];
    assign mem_fault_o   = fault_i[xosvm_pkg::CH_DATA];

    // Faulting data access never reaches memory
    assign mem_op_en_o   = mem_req && !fault_i[xosvm_pkg::CH_DATA];

    // Byte strobes killed on a data fault
    assign mem_we_o      = fault_i[xosvm_pkg::CH_DATA] ? '0 : mem_we_i;

    // Enable must not come up during a data fault
    a_no_op_on_fault: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $rose(mem_op_en_o) |-> !mem_fault_o
    );

endmodule

`default_nettype wire

// File: design/region_mmu.sv
// XOSVM region translator
`timescale 1ns/1ps
`default_nettype none

module region_mmu (
    // Protection active for this access
    input  logic                        en_i,

    // Incoming virtual address
    input  logic [xosvm_pkg::XLEN-1:0]  addr_i,

    // Region description
    input  logic [xosvm_pkg::XLEN-1:0]  offset_i,
    input  logic [xosvm_pkg::XLEN-1:0]  size_i,
    input  logic [xosvm_pkg::XLEN-1:0]  mask_i,

    // Physical address and access fault
    output logic [xosvm_pkg::XLEN-1:0]  addr_o,
    output logic                        fault_o
);

    // Address bits kept inside the region
    logic [xosvm_pkg::XLEN-1:0]  masked_addr;
    // Relocated address, wraps at 2^32
    logic [xosvm_pkg::XLEN-1:0]  reloc_addr;
    // Access at or past the region end
    logic                        out_of_range;

    assign masked_addr  = addr_i & mask_i;
    assign reloc_addr   = masked_addr + offset_i;
    // Size is the first illegal address
    assign out_of_range = (addr_i >= size_i);

    always_comb begin
        if (en_i) begin
            addr_o  = reloc_addr;
            fault_o = out_of_range;
        end
        else begin
            // Protection off, address untouched
            addr_o  = addr_i;
            fault_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/xosvm_csr.sv
// XOSVM region registers
`timescale 1ns/1ps
`default_nettype none

module xosvm_csr (
    input  logic                                                     clk,
    input  logic                                                     rst_n_i,

    // CSR strobe port
    input  logic                                                     csr_we_i,
    input  logic [xosvm_pkg::CSR_ADDR_W-1:0]                         csr_addr_i,
    input  logic [xosvm_pkg::XLEN-1:0]                               csr_wdata_i,
    output logic [xosvm_pkg::XLEN-1:0]                               csr_rdata_o,

    // Current hart privilege
    input  xosvm_pkg::priv_lvl_e                                     priv_i,

    // Region setup per translator channel
    output logic                                                     prot_en_o,
    output logic [xosvm_pkg::NUM_CHANNELS-1:0][xosvm_pkg::XLEN-1:0]  offset_o,
    output logic [xosvm_pkg::NUM_CHANNELS-1:0][xosvm_pkg::XLEN-1:0]  size_o,
    output logic [xosvm_pkg::NUM_CHANNELS-1:0][xosvm_pkg::XLEN-1:0]  mask_o
);

//////////////////////////////
// Register storage
//////////////////////////////

    // Protection switch
    logic                         mvmctl;
    // Data region
    logic [xosvm_pkg::XLEN-1:0]   mvmdo;
    logic [xosvm_pkg::XLEN-1:0]   mvmds;
    logic [xosvm_pkg::XLEN-1:0]   mvmdm;
    // Instruction region
    logic [xosvm_pkg::XLEN-1:0]   mvmio;
    logic [xosvm_pkg::XLEN-1:0]   mvmis;
    logic [xosvm_pkg::XLEN-1:0]   mvmim;

    // Plain full writes, no set or clear forms
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mvmctl <= 1'b0;
            mvmdo  <= '0;
            mvmds  <= '0;
            mvmdm  <= '0;
            mvmio  <= '0;
            mvmis  <= '0;
            mvmim  <= '0;
        end
        else if (csr_we_i) begin
            case (csr_addr_i)
                // Upper control bits are not stored
                xosvm_pkg::CSR_MVMCTL: mvmctl <= csr_wdata_i[0];
                xosvm_pkg::CSR_MVMDO:  mvmdo  <= csr_wdata_i;
                xosvm_pkg::CSR_MVMDS:  mvmds  <= csr_wdata_i;
                xosvm_pkg::CSR_MVMDM:  mvmdm  <= csr_wdata_i;
                xosvm_pkg::CSR_MVMIO:  mvmio  <= csr_wdata_i;
                xosvm_pkg::CSR_MVMIS:  mvmis  <= csr_wdata_i;
                xosvm_pkg::CSR_MVMIM:  mvmim  <= csr_wdata_i;
                // Writes elsewhere are dropped
                default: begin
                end
            endcase
        end
    end

//////////////////////////////
// Read path
//////////////////////////////

    // Combinational read of the addressed register
    always_comb begin
        case (csr_addr_i)
            xosvm_pkg::CSR_MVMCTL: csr_rdata_o = {{(xosvm_pkg::XLEN-1){1'b0}}, mvmctl};
            xosvm_pkg::CSR_MVMDO:  csr_rdata_o = mvmdo;
            xosvm_pkg::CSR_MVMDS:  csr_rdata_o = mvmds;
            xosvm_pkg::CSR_MVMDM:  csr_rdata_o = mvmdm;
            xosvm_pkg::CSR_MVMIO:  csr_rdata_o = mvmio;
            xosvm_pkg::CSR_MVMIS:  csr_rdata_o = mvmis;
            xosvm_pkg::CSR_MVMIM:  csr_rdata_o = mvmim;
            // Unmapped addresses read as zero
            default:               csr_rdata_o = '0;
        endcase
    end

//////////////////////////////
// Channel mapping
//////////////////////////////

    // Instruction triple to the fetch channel
    assign offset_o[xosvm_pkg::CH_INSTR] = mvmio;
    assign size_o[xosvm_pkg::CH_INSTR]   = mvmis;
    assign mask_o[xosvm_pkg::CH_INSTR]   = mvmim;

    // Data triple to the load/store channel
    assign offset_o[xosvm_pkg::CH_DATA]  = mvmdo;
    assign size_o[xosvm_pkg::CH_DATA]    = mvmds;
    assign mask_o[xosvm_pkg::CH_DATA]    = mvmdm;

    // Machine mode always sees physical addresses
    assign prot_en_o = mvmctl && (priv_i != xosvm_pkg::PRIV_MACHINE);

//////////////////////////////
// Checks
//////////////////////////////

    // Read data stays defined once out of reset
    a_rdata_known: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !$isunknown(csr_rdata_o)
    );

    // Control write never shows more than bit 0 afterwards
    a_ctl_upper_zero: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (csr_we_i && csr_addr_i == xosvm_pkg::CSR_MVMCTL)
        |=> (csr_addr_i != xosvm_pkg::CSR_MVMCTL) || (csr_rdata_o[xosvm_pkg::XLEN-1:1] == '0)
    );

endmodule

`default_nettype wire

// File: design/xosvm_pkg.sv
// XOSVM shared definitions
`default_nettype none

package xosvm_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // Data and address width in bits
    localparam int XLEN       = 32;
    // CSR address field
    localparam int CSR_ADDR_W = 12;
    // Byte write enables of one word
    localparam int WE_W       = 4;

    //////////////////////////////
    // Translator channels
    //////////////////////////////

    localparam int NUM_CHANNELS = 2;
    // Instruction fetch side
    localparam int CH_INSTR     = 0;
    // Load and store side
    localparam int CH_DATA      = 1;

    //////////////////////////////
    // Privilege levels
    //////////////////////////////

    // Encoding 2 is reserved and never produced
    typedef enum logic [1:0] {
        PRIV_USER       = 2'b00,
        PRIV_SUPERVISOR = 2'b01,
        PRIV_MACHINE    = 2'b11
    } priv_lvl_e;

    //////////////////////////////
    // XOSVM CSR map
    //////////////////////////////

    // Control, only bit 0 exists
    localparam logic [CSR_ADDR_W-1:0] CSR_MVMCTL = 12'h7C0;
    // Data region offset, size, mask
    localparam logic [CSR_ADDR_W-1:0] CSR_MVMDO  = 12'h7C1;
    localparam logic [CSR_ADDR_W-1:0] CSR_MVMDS  = 12'h7C2;
    localparam logic [CSR_ADDR_W-1:0] CSR_MVMDM  = 12'h7C3;
    // Instruction region offset, size, mask
    localparam logic [CSR_ADDR_W-1:0] CSR_MVMIO  = 12'h7C4;
    localparam logic [CSR_ADDR_W-1:0] CSR_MVMIS  = 12'h7C5;
    localparam logic [CSR_ADDR_W-1:0] CSR_MVMIM  = 12'h7C6;

endpackage

`default_nettype wire

// File: design/xosvm_top.sv
// XOSVM protection unit top
`timescale 1ns/1ps
`default_nettype none

module xosvm_top (
    input  logic                                clk,
    input  logic                                rst_n_i,

    // CSR access
    input  logic                                csr_we_i,
    input  logic [xosvm_pkg::CSR_ADDR_W-1:0]    csr_addr_i,
    input  logic [xosvm_pkg::XLEN-1:0]          csr_wdata_i,
    output logic [xosvm_pkg::XLEN-1:0]          csr_rdata_o,

    // Privilege of the running code
    input  xosvm_pkg::priv_lvl_e                priv_i,

    // Untranslated requests
    input  logic [xosvm_pkg::XLEN-1:0]          instr_addr_i,
    input  logic [xosvm_pkg::XLEN-1:0]          mem_addr_i,
    input  logic                                mem_read_i,
    input  logic [xosvm_pkg::WE_W-1:0]          mem_we_i,

    // Fetch bus
    output logic [xosvm_pkg::XLEN-1:0]          instr_addr_o,
    output logic                                instr_fault_o,

    // Data bus
    output logic [xosvm_pkg::XLEN-1:0]          mem_addr_o,
    output logic                                mem_fault_o,
    output logic                                mem_op_en_o,
    output logic [xosvm_pkg::WE_W-1:0]          mem_we_o
);

//////////////////////////////
// Internal nets
//////////////////////////////

    // Shared enable of both translators
    logic                                                     prot_en;

    // Region triple per channel
    logic [xosvm_pkg::NUM_CHANNELS-1:0][xosvm_pkg::XLEN-1:0]  ch_offset;
    logic [xosvm_pkg::NUM_CHANNELS-1:0][xosvm_pkg::XLEN-1:0]  ch_size;
    logic [xosvm_pkg::NUM_CHANNELS-1:0][xosvm_pkg::XLEN-1:0]  ch_mask;

    // Addresses before and after translation
    logic [xosvm_pkg::NUM_CHANNELS-1:0][xosvm_pkg::XLEN-1:0]  ch_addr_in;
    logic [xosvm_pkg::NUM_CHANNELS-1:0][xosvm_pkg::XLEN-1:0]  ch_addr_out;
    logic [xosvm_pkg::NUM_CHANNELS-1:0]                       ch_fault;

    // Channel 0 fetch, channel 1 load/store
    assign ch_addr_in[xosvm_pkg::CH_INSTR] = instr_addr_i;
    assign ch_addr_in[xosvm_pkg::CH_DATA]  = mem_addr_i;

//////////////////////////////
// Region registers
//////////////////////////////

    xosvm_csr csr_bank1 (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .csr_we_i       (csr_we_i),
        .csr_addr_i     (csr_addr_i),
        .csr_wdata_i    (csr_wdata_i),
        .csr_rdata_o    (csr_rdata_o),
        .priv_i         (priv_i),
        .prot_en_o      (prot_en),
        .offset_o       (ch_offset),
        .size_o         (ch_size),
        .mask_o         (ch_mask)
    );

//////////////////////////////
// Translators
//////////////////////////////

    // Same translator on every channel
    for (genvar ch = 0; ch < xosvm_pkg::NUM_CHANNELS; ch++) begin : gen_channel
        region_mmu mmu1 (
            .en_i       (prot_en),
            .addr_i     (ch_addr_in[ch]),
            .offset_i   (ch_offset[ch]),
            .size_i     (ch_size[ch]),
            .mask_i     (ch_mask[ch]),
            .addr_o     (ch_addr_out[ch]),
            .fault_o    (ch_fault[ch])
        );
    end

//////////////////////////////
// Memory side
//////////////////////////////

    access_gate gate1 (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .addr_i         (ch_addr_out),
        .fault_i        (ch_fault),
        .mem_read_i     (mem_read_i),
        .mem_we_i       (mem_we_i),
        .instr_addr_o   (instr_addr_o),
        .instr_fault_o  (instr_fault_o),
        .mem_addr_o     (mem_addr_o),
        .mem_fault_o    (mem_fault_o),
        .mem_op_en_o    (mem_op_en_o),
        .mem_we_o       (mem_we_o)
    );

endmodule

`default_nettype wire

// File: files.f
+incdir+include
design/xosvm_pkg.sv
design/region_mmu.sv
design/access_gate.sv
design/xosvm_csr.sv
design/xosvm_top.sv
test/xosvm_tb.sv

// File: include/xosvm_tb_cases.svh
// XOSVM testbench case table
`ifndef XOSVM_TB_CASES_SVH
`define XOSVM_TB_CASES_SVH

// One applied cycle and what the outputs must show
typedef struct packed {
    logic [3:0]                         test_id;
    // Outputs compared on this row
    logic                               chk;
    logic                               csr_we;
    logic [xosvm_pkg::CSR_ADDR_W-1:0]   csr_addr;
    logic [xosvm_pkg::XLEN-1:0]         csr_wdata;
    // Raw encoding, 0 user and 3 machine
    logic [1:0]                         priv;
    logic [xosvm_pkg::XLEN-1:0]         instr_addr;
    logic [xosvm_pkg::XLEN-1:0]         mem_addr;
    // Data address drawn at run time, modulo the data region size
    logic                               mem_rand;
    logic                               mem_read;
    logic [xosvm_pkg::WE_W-1:0]         mem_we;
    logic [xosvm_pkg::XLEN-1:0]         exp_rdata;
    logic [xosvm_pkg::XLEN-1:0]         exp_instr_addr;
    logic                               exp_instr_fault;
    // Ignored on random rows
    logic [xosvm_pkg::XLEN-1:0]         exp_mem_addr;
    logic                               exp_mem_fault;
    logic                               exp_mem_op_en;
    logic [xosvm_pkg::WE_W-1:0]         exp_mem_we;
} tb_case_t;

localparam int NUM_TB_CASES = 32;

// Region used: data at 0x10000 size 0x1000 mask 0xFFF, instr at 0x20000 size 0x800 mask 0x7FF
// id chk we addr wdata priv ia ma rnd rd we | rdata ia if ma mf op we
localparam tb_case_t TB_CASES [NUM_TB_CASES] = '{
    '{1, 1, 0, 'h7C0, 'h0, 0, 'h100, 'h2000, 0, 1, 'h0, 'h0, 'h100, 0, 'h2000, 0, 1, 'h0},
    '{1, 1, 0, 'h7C1, 'h0, 0, 'h104, 'h2004, 0, 0, 'h3, 'h0, 'h104, 0, 'h2004, 0, 1, 'h3},
    '{1, 1, 0, 'h7C2, 'h0, 0, 'h108, 'h2008, 0, 1, 'h0, 'h0, 'h108, 0, 'h2008, 0, 1, 'h0},
    '{1, 1, 0, 'h7C3, 'h0, 0, 'h3000, 'h5004, 0, 0, 'h0, 'h0, 'h3000, 0, 'h5004, 0, 0, 'h0},
    '{1, 1, 0, 'h7C4, 'h0, 0, 'h10C, 'h200C, 0, 0, 'h0, 'h0, 'h10C, 0, 'h200C, 0, 0, 'h0},
    '{1, 1, 0, 'h7C5, 'h0, 0, 'h110, 'h2010, 0, 1, 'h8, 'h0, 'h110, 0, 'h2010, 0, 1, 'h8},
    '{1, 1, 0, 'h7C6, 'h0, 0, 'hFFFC, 'h8000, 0, 0, 'hC, 'h0, 'hFFFC, 0, 'h8000, 0, 1, 'hC},
    '{2, 0, 1, 'h7C1, 'h1_0000, 0, 'h0, 'h0, 0, 0, 'h0, 'h0, 'h0, 0, 'h0, 0, 0, 'h0},
    '{2, 1, 0, 'h7C1, 'h0, 0, 'h40, 'h80, 0, 1, 'h0, 'h1_0000, 'h40, 0, 'h80, 0, 1, 'h0},
    '{2, 0, 1, 'h7C2, 'h1000, 0, 'h0, 'h0, 0, 0, 'h0, 'h0, 'h0, 0, 'h0, 0, 0, 'h0},
    '{2, 1, 0, 'h7C2, 'h0, 0, 'h40, 'h80, 0, 1, 'h0, 'h1000, 'h40, 0, 'h80, 0, 1, 'h0},
    '{2, 0, 1, 'h7C3, 'hFFF, 0, 'h0, 'h0, 0, 0, 'h0, 'h0, 'h0, 0, 'h0, 0, 0, 'h0},
    '{2, 1, 0, 'h7C3, 'h0, 0, 'h40, 'h80, 0, 1, 'h0, 'hFFF, 'h40, 0, 'h80, 0, 1, 'h0},
    '{2, 0, 1, 'h7C4, 'h2_0000, 0, 'h0, 'h0, 0, 0, 'h0, 'h0, 'h0, 0, 'h0, 0, 0, 'h0},
    '{2, 1, 0, 'h7C4, 'h0, 0, 'h40, 'h80, 0, 1, 'h0, 'h2_0000, 'h40, 0, 'h80, 0, 1, 'h0},
    '{2, 0, 1, 'h7C5, 'h800, 0, 'h0, 'h0, 0, 0, 'h0, 'h0, 'h0, 0, 'h0, 0, 0, 'h0},
    '{2, 1, 0, 'h7C5, 'h0, 0, 'h40, 'h80, 0, 1, 'h0, 'h800, 'h40, 0, 'h80, 0, 1, 'h0},
    '{2, 0, 1, 'h7C6, 'h7FF, 0, 'h0, 'h0, 0, 0, 'h0, 'h0, 'h0, 0, 'h0, 0, 0, 'h0},
    '{2, 1, 0, 'h7C6, 'h0, 0, 'h40, 'h80, 0, 1, 'h0, 'h7FF, 'h40, 0, 'h80, 0, 1, 'h0},
    '{2, 0, 1, 'h7C0, 'hFFFF_FFFF, 0, 'h0, 'h0, 0, 0, 'h0, 'h0, 'h0, 0, 'h0, 0, 0, 'h0},
    '{2, 1, 0, 'h7C0, 'h0, 0, 'h40, 'h80, 0, 1, 'h0, 'h1, 'h2_0040, 0, 'h1_0080, 0, 1, 'h0},
    '{2, 1, 0, 'h7C7, 'h0, 0, 'h44, 'h84, 0, 0, 'h1, 'h0, 'h2_0044, 0, 'h1_0084, 0, 1, 'h1},
    '{3, 1, 0, 'h7C0, 'h0, 0, 'h123, 'hABC, 0, 1, 'h0, 'h1, 'h2_0123, 0, 'h1_0ABC, 0, 1, 'h0},
    '{3, 1, 0, 'h7C3, 'h0, 0, 'h7FF, 'hFFC, 0, 0, 'hF, 'hFFF, 'h2_07FF, 0, 'h1_0FFC, 0, 1, 'hF},
    '{3, 1, 0, 'h7C1, 'h0, 0, 'h400, 'h0, 1, 0, 'h3, 'h1_0000, 'h2_0400, 0, 'h0, 0, 1, 'h3},
    '{3, 1, 0, 'h7C4, 'h0, 0, 'h7FE, 'h0, 1, 1, 'h0, 'h2_0000, 'h2_07FE, 0, 'h0, 0, 1, 'h0},
    '{4, 1, 0, 'h7C2, 'h0, 0, 'h100, 'h1000, 0, 0, 'hF, 'h1000, 'h2_0100, 0, 'h1_0000, 1, 0, 'h0},
    '{4, 1, 0, 'h7C5, 'h0, 0, 'h800, 'h8000_0000, 0, 1, 'h0, 'h800, 'h2_0000, 1, 'h1_0000, 1, 0, 'h0},
    '{4, 1, 0, 'h7C6, 'h0, 0, 'hFFFF_FFFF, 'h10, 0, 0, 'h2, 'h7FF, 'h2_07FF, 1, 'h1_0010, 0, 1, 'h2},
    '{5, 1, 0, 'h7C4, 'h0, 3, 'h800, 'h1000, 0, 1, 'hF, 'h2_0000, 'h800, 0, 'h1000, 0, 1, 'hF},
    '{5, 0, 1, 'h7C0, 'h0, 0, 'h0, 'h0, 0, 0, 'h0, 'h0, 'h0, 0, 'h0, 0, 0, 'h0},
    '{5, 1, 0, 'h7C0, 'h0, 0, 'h800, 'h1000, 0, 0, 'h1, 'h0, 'h800, 0, 'h1000, 0, 1, 'h1}
};

`endif

// File: test/xosvm_tb.sv
// XOSVM protection unit testbench
`timescale 1ns/1ps
`default_nettype none

module xosvm_tb;

`include "xosvm_tb_cases.svh"

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    // Reset, two cycles per row, then some slack
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_TB_CASES * 2 + 20;

    // DUT inputs
    logic                               clk;
    logic                               rst_n_i;
    logic                               csr_we_i;
    logic [xosvm_pkg::CSR_ADDR_W-1:0]   csr_addr_i;
    logic [xosvm_pkg::XLEN-1:0]         csr_wdata_i;
    xosvm_pkg::priv_lvl_e               priv_i;
    logic [xosvm_pkg::XLEN-1:0]         instr_addr_i;
    logic [xosvm_pkg::XLEN-1:0]         mem_addr_i;
    logic                               mem_read_i;
    logic [xosvm_pkg::WE_W-1:0]         mem_we_i;

    // DUT outputs
    logic [xosvm_pkg::XLEN-1:0]         csr_rdata_o;
    logic [xosvm_pkg::XLEN-1:0]         instr_addr_o;
    logic                               instr_fault_o;
    logic [xosvm_pkg::XLEN-1:0]         mem_addr_o;
    logic                               mem_fault_o;
    logic                               mem_op_en_o;
    logic [xosvm_pkg::WE_W-1:0]         mem_we_o;

    // Model of the data region registers
    logic                               shadow_ctl;
    logic [xosvm_pkg::XLEN-1:0]         shadow_do;
    logic [xosvm_pkg::XLEN-1:0]         shadow_ds;
    logic [xosvm_pkg::XLEN-1:0]         shadow_dm;

    // Bookkeeping
    integer                             seed;
    int                                 cycle_count;
    int                                 test_errs;
    int                                 tests_passed;
    int                                 tests_failed;
    int                                 cur_test;
    int                                 row_idx;

    xosvm_top dut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .csr_we_i       (csr_we_i),
        .csr_addr_i     (csr_addr_i),
        .csr_wdata_i    (csr_wdata_i),
        .csr_rdata_o    (csr_rdata_o),
        .priv_i         (priv_i),
        .instr_addr_i   (instr_addr_i),
        .mem_addr_i     (mem_addr_i),
        .mem_read_i     (mem_read_i),
        .mem_we_i       (mem_we_i),
        .instr_addr_o   (instr_addr_o),
        .instr_fault_o  (instr_fault_o),
        .mem_addr_o     (mem_addr_o),
        .mem_fault_o    (mem_fault_o),
        .mem_op_en_o    (mem_op_en_o),
        .mem_we_o       (mem_we_o)
    );

//////////////////////////////
// Clock and watchdog
//////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Stops a stuck run
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= CYCLE_LIMIT) begin
                $display("Run timed out after %0d cycles", cycle_count);
                $display("Something failed");
                $finish;
            end
        end
    end

//////////////////////////////
// Helpers
//////////////////////////////

    // Compare one output, report in hex
    task automatic compare_value(input string sig_name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("ERR %s expected %h actual %h", sig_name, exp_val, act_val);
            test_errs++;
        end
    endtask

    // One summary line per finished test
    task automatic close_test(input int id);
        if (test_errs == 0) begin
            $display("Test %0d passed", id);
            tests_passed++;
        end
        else begin
            $display("Test %0d failed with %0d errors", id, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // Drive one table row, then check it mid cycle
    task automatic run_row(input int idx);
        tb_case_t                   row;
        logic [xosvm_pkg::XLEN-1:0] drawn;
        logic [xosvm_pkg::XLEN-1:0] exp_maddr;
        logic                       exp_mfault;
        logic                       exp_op;
        logic [xosvm_pkg::WE_W-1:0] exp_we;
        logic                       prot_active;
        row = TB_CASES[idx];
        @(negedge clk);
        csr_we_i     = row.csr_we;
        csr_addr_i   = row.csr_addr;
        csr_wdata_i  = row.csr_wdata;
        priv_i       = xosvm_pkg::priv_lvl_e'(row.priv);
        instr_addr_i = row.instr_addr;
        mem_read_i   = row.mem_read;
        mem_we_i     = row.mem_we;
        exp_maddr    = row.exp_mem_addr;
        exp_mfault   = row.exp_mem_fault;
        exp_op       = row.exp_mem_op_en;
        exp_we       = row.exp_mem_we;
        if (row.mem_rand) begin
            // Keep the draw inside the data region
            drawn = $unsigned($random(seed));
            if (shadow_ds != '0) begin
                drawn = drawn % shadow_ds;
            end
            mem_addr_i  = drawn;
            prot_active = shadow_ctl && (row.priv != 2'b11);
            if (prot_active) begin
                exp_maddr  = (drawn & shadow_dm) + shadow_do;
                exp_mfault = (drawn >= shadow_ds);
            end
            else begin
                exp_maddr  = drawn;
                exp_mfault = 1'b0;
            end
            exp_op = (row.mem_read || (row.mem_we != '0)) && !exp_mfault;
            exp_we = exp_mfault ? '0 : row.mem_we;
        end
        else begin
            mem_addr_i = row.mem_addr;
        end
        // Comb path settled, well clear of the rising edge
        #(CLK_PERIOD/4);
        if (row.chk) begin
            compare_value("csr_rdata_o", row.exp_rdata, csr_rdata_o);
            compare_value("instr_addr_o", row.exp_instr_addr, instr_addr_o);
            compare_value("instr_fault_o", 32'(row.exp_instr_fault), 32'(instr_fault_o));
            compare_value("mem_addr_o", exp_maddr, mem_addr_o);
            compare_value("mem_fault_o", 32'(exp_mfault), 32'(mem_fault_o));
            compare_value("mem_op_en_o", 32'(exp_op), 32'(mem_op_en_o));
            compare_value("mem_we_o", 32'(exp_we), 32'(mem_we_o));
        end
        // Track data region for random rows
        if (row.csr_we) begin
            case (row.csr_addr)
                xosvm_pkg::CSR_MVMCTL: shadow_ctl = row.csr_wdata[0];
                xosvm_pkg::CSR_MVMDO:  shadow_do  = row.csr_wdata;
                xosvm_pkg::CSR_MVMDS:  shadow_ds  = row.csr_wdata;
                xosvm_pkg::CSR_MVMDM:  shadow_dm  = row.csr_wdata;
                default: begin
                end
            endcase
        end
    endtask

//////////////////////////////
// Main sequence
//////////////////////////////

    initial begin
        seed         = 32'h8b5962d0;
        rst_n_i      = 1'b0;
        csr_we_i     = 1'b0;
        csr_addr_i   = '0;
        csr_wdata_i  = '0;
        priv_i       = xosvm_pkg::PRIV_USER;
        instr_addr_i = '0;
        mem_addr_i   = '0;
        mem_read_i   = 1'b0;
        mem_we_i     = '0;
        shadow_ctl   = 1'b0;
        shadow_do    = '0;
        shadow_ds    = '0;
        shadow_dm    = '0;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i  = 1'b1;
        cur_test = TB_CASES[0].test_id;
        for (row_idx = 0; row_idx < NUM_TB_CASES; row_idx++) begin
            // New test id closes the previous one
            if (TB_CASES[row_idx].test_id != cur_test) begin
                close_test(cur_test);
                cur_test = TB_CASES[row_idx].test_id;
            end
            run_row(row_idx);
        end
        close_test(cur_test);
        $display("Tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Everything OK");
        end
        else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
